/* logic/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// width of pc and data path
`define XLEN 64
// fetch virtual address, upper pc bits are not looked at
`define VADDR_W 40
// first fetch after reset
`define RESET_PC 64'h200
// byte address bits of the 4 KB memory
`define MEM_ADDR_W 12
// log2 of the 256 byte page
`define PAGE_W 8
`define N_PAGES 16

`endif

/* logic/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

    // base opcodes, no compressed set
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_IMM      = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP_ALU      = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111,
        OP_SYSTEM   = 7'b1110011
    } opcode_t;

    // mcause codes of the fetch exceptions
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1,
        INSTR_PAGE_FAULT      = 4'd12
    } exc_cause_t;

    // b-type layout, scattered 13 bit offset
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } btype_t;

    // j-type layout, scattered 21 bit offset
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } jtype_t;

    // same word seen as branch or as jal
    typedef union packed {
        btype_t btype;
        jtype_t jtype;
    } rv_instr_t;

endpackage

`default_nettype wire

/* logic/fetch_pkg.sv */
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    import riscv_pkg::*;

    // full width program counter
    typedef logic [`XLEN-1:0] addr_pc_t;

    // next pc choice from the control unit
    // 2'b11 is left undefined
    typedef enum logic [1:0] {
        NEXT_PC_SEL_PC   = 2'b00,
        NEXT_PC_SEL_PC_4 = 2'b01,
        NEXT_PC_SEL_JUMP = 2'b10
    } next_pc_sel_t;

    // static prediction for one fetched word
    typedef struct packed {
        logic     taken;
        addr_pc_t pred_addr;
    } bpred_t;

    // fetch exception, origin is the faulting pc
    typedef struct packed {
        logic       valid;
        exc_cause_t cause;
        addr_pc_t   origin;
    } exc_t;

    // what fetch hands to decode
    typedef struct packed {
        logic      valid;
        addr_pc_t  pc;
        rv_instr_t instr;
        bpred_t    bpred;
        exc_t      ex;
    } fetch_out_t;

endpackage

`default_nettype wire

/* logic/mem_bus_if.sv */
`default_nettype none

`include "fetch_macros.svh"

// one single cycle port to the instruction memory
interface mem_bus_if (
    input wire logic clk_i,
    input wire logic rstn_i
);

    logic                req;
    logic                we;
    // full virtual address so the memory can see out of range fetches
    logic [`VADDR_W-1:0] addr;
    logic [31:0]         wdata;
    logic [31:0]         rdata;
    logic                rvalid;
    logic                access_fault;
    logic                page_fault;

    modport requester (
        input  clk_i, rstn_i,
        output req, we, addr, wdata,
        input  rdata, rvalid, access_fault, page_fault
    );

    modport memory (
        input  clk_i, rstn_i,
        input  req, we, addr, wdata,
        output rdata, rvalid, access_fault, page_fault
    );

endinterface

`default_nettype wire

/* logic/branch_predecoder.sv */
`default_nettype none

`include "fetch_macros.svh"

module branch_predecoder
    import riscv_pkg::*;
    import fetch_pkg::*;
(
    input  wire rv_instr_t instr_i,
    input  wire addr_pc_t  pc_i,
    input  wire logic      valid_i,
    output bpred_t         bpred_o
);

    addr_pc_t imm_b;
    addr_pc_t imm_j;

    // sign extended offsets, bit 0 always zero
    assign imm_b = {{(`XLEN-12){instr_i.btype.imm12}}, instr_i.btype.imm11,
                    instr_i.btype.imm10_5, instr_i.btype.imm4_1, 1'b0};
    assign imm_j = {{(`XLEN-20){instr_i.jtype.imm20}}, instr_i.jtype.imm19_12,
                    instr_i.jtype.imm11, instr_i.jtype.imm10_1, 1'b0};

    always_comb begin
        bpred_o.taken     = 1'b0;
        bpred_o.pred_addr = '0;
        if (valid_i) begin
            // backward branches are usually loops
            if (instr_i.btype.opcode == OP_BRANCH && instr_i.btype.imm12) begin
                bpred_o.taken     = 1'b1;
                bpred_o.pred_addr = pc_i + imm_b;
            end else if (instr_i.jtype.opcode == OP_JAL) begin
                // jal always jumps
                bpred_o.taken     = 1'b1;
                bpred_o.pred_addr = pc_i + imm_j;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/if_stage.sv */
`default_nettype none

`include "fetch_macros.svh"

module if_stage
    import riscv_pkg::*;
    import fetch_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          rstn_i,
    input  wire logic          stall_i,
    input  wire next_pc_sel_t  next_pc_sel_i,
    // target from commit, decode or ecall
    input  wire addr_pc_t      pc_jump_i,
    mem_bus_if.requester       fetch_bus,
    output fetch_out_t         fetch_o
);

    addr_pc_t pc_q;
    addr_pc_t pc_d;
    bpred_t   bpred;
    exc_t     exc;

    logic ex_misaligned;
    logic ex_access_fault;
    logic ex_page_fault;

    // next pc mux
    always_comb begin
        case (next_pc_sel_i)
            NEXT_PC_SEL_PC:   pc_d = pc_q;
            NEXT_PC_SEL_PC_4: pc_d = pc_q + `XLEN'd4;
            NEXT_PC_SEL_JUMP: pc_d = pc_jump_i;
            // undefined select, keep going sequentially
            default:          pc_d = pc_q + `XLEN'd4;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // misalignment found here, other two come back from memory
    assign ex_misaligned   = |pc_q[1:0];
    assign ex_access_fault = fetch_bus.rvalid & fetch_bus.access_fault;
    assign ex_page_fault   = fetch_bus.rvalid & fetch_bus.page_fault;

    // no request for a misaligned pc or while stalled
    assign fetch_bus.req   = !ex_misaligned & !stall_i;
    assign fetch_bus.we    = 1'b0;
    assign fetch_bus.addr  = pc_q[`VADDR_W-1:0];
    assign fetch_bus.wdata = '0;

    // fixed priority, misaligned first
    always_comb begin
        exc.origin = pc_q;
        if (ex_misaligned) begin
            exc.valid = 1'b1;
            exc.cause = INSTR_ADDR_MISALIGNED;
        end else if (ex_access_fault) begin
            exc.valid = 1'b1;
            exc.cause = INSTR_ACCESS_FAULT;
        end else if (ex_page_fault) begin
            exc.valid = 1'b1;
            exc.cause = INSTR_PAGE_FAULT;
        end else begin
            exc.valid = 1'b0;
            exc.cause = INSTR_ADDR_MISALIGNED;
        end
    end

    branch_predecoder u_predecoder (
        .instr_i (fetch_bus.rdata),
        .pc_i    (pc_q),
        .valid_i (fetch_bus.rvalid),
        .bpred_o (bpred)
    );

    assign fetch_o.valid = fetch_bus.rvalid;
    assign fetch_o.pc    = pc_q;
    assign fetch_o.instr = fetch_bus.rdata;
    assign fetch_o.bpred = bpred;
    assign fetch_o.ex    = exc;

    // control unit should never send the spare encoding
    a_next_pc_sel_defined : assert property (@(posedge clk_i) disable iff (!rstn_i)
        next_pc_sel_i inside {NEXT_PC_SEL_PC, NEXT_PC_SEL_PC_4, NEXT_PC_SEL_JUMP})
        else $warning("undefined next pc select, taking pc plus 4");

    // memory answers only what was asked, so a valid word is never misaligned
    a_valid_aligned : assert property (@(posedge clk_i) disable iff (!rstn_i)
        fetch_bus.rvalid |-> !ex_misaligned && !stall_i);

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`default_nettype none

`include "fetch_macros.svh"

module mem_arbiter (
    input  wire logic                   host_we_i,
    input  wire logic [`MEM_ADDR_W-1:0] host_addr_i,
    input  wire logic [31:0]            host_wdata_i,
    mem_bus_if.memory                   fetch_bus,
    mem_bus_if.requester                tcm_bus
);

    // host write strobe takes the port outright
    assign tcm_bus.req   = host_we_i | fetch_bus.req;
    assign tcm_bus.we    = host_we_i ? 1'b1 : fetch_bus.we;
    // host only reaches the 4 KB window, upper bits zero
    assign tcm_bus.addr  = host_we_i ? {{(`VADDR_W-`MEM_ADDR_W){1'b0}}, host_addr_i}
                                     : fetch_bus.addr;
    assign tcm_bus.wdata = host_we_i ? host_wdata_i : fetch_bus.wdata;

    // losing fetch gets nothing back, no retry
    assign fetch_bus.rvalid       = !host_we_i & tcm_bus.rvalid;
    assign fetch_bus.rdata        = tcm_bus.rdata;
    assign fetch_bus.access_fault = !host_we_i & tcm_bus.access_fault;
    assign fetch_bus.page_fault   = !host_we_i & tcm_bus.page_fault;

    // a word handed to fetch was read at the fetch address, never on a host cycle
    a_no_fetch_on_host : assert property (
        @(posedge fetch_bus.clk_i) disable iff (!fetch_bus.rstn_i)
        fetch_bus.rvalid |-> !host_we_i && tcm_bus.addr == fetch_bus.addr);

endmodule

`default_nettype wire

/* logic/inst_tcm.sv */
`default_nettype none

`include "fetch_macros.svh"

module inst_tcm (
    input  wire logic                           clk_i,
    input  wire logic                           rstn_i,
    mem_bus_if.memory                           tcm_bus,
    // set or clear exec permission of one page
    input  wire logic                           host_perm_we_i,
    input  wire logic [`MEM_ADDR_W-`PAGE_W-1:0] host_perm_page_i,
    input  wire logic                           host_perm_exec_i
);

    localparam int unsigned N_WORDS = 2 ** (`MEM_ADDR_W - 2);

    logic [31:0]             mem [N_WORDS];
    logic [`N_PAGES-1:0]     exec_q;
    logic [`MEM_ADDR_W-3:0]  word_idx;
    logic [`MEM_ADDR_W-`PAGE_W-1:0] page_idx;
    logic                    out_of_range;
    logic                    write_en;

    assign word_idx = tcm_bus.addr[`MEM_ADDR_W-1:2];
    assign page_idx = tcm_bus.addr[`MEM_ADDR_W-1:`PAGE_W];

    // anything above the 4 KB window is unmapped
    assign out_of_range = |tcm_bus.addr[`VADDR_W-1:`MEM_ADDR_W];
    assign write_en     = tcm_bus.req & tcm_bus.we & !out_of_range;

    // word array
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            mem[word_idx] <= tcm_bus.wdata;
        end
    end

    // every page comes up executable
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            exec_q <= '1;
        end else if (host_perm_we_i) begin
            exec_q[host_perm_page_i] <= host_perm_exec_i;
        end
    end

    // same cycle read
    assign tcm_bus.rdata  = mem[word_idx];
    assign tcm_bus.rvalid = tcm_bus.req;

    assign tcm_bus.access_fault = tcm_bus.req & out_of_range;
    // exec permission only matters for a read
    assign tcm_bus.page_fault = tcm_bus.req & !tcm_bus.we & !exec_q[page_idx];

    // host writes arrive zero extended from the arbiter
    a_write_in_range : assert property (@(posedge clk_i) disable iff (!rstn_i)
        tcm_bus.req && tcm_bus.we |-> !tcm_bus.access_fault);

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`default_nettype none

`include "fetch_macros.svh"

module fetch_top
    import riscv_pkg::*;
    import fetch_pkg::*;
(
    input  wire logic                           clk_i,
    input  wire logic                           rstn_i,
    // control unit
    input  wire logic                           stall_i,
    input  wire next_pc_sel_t                   next_pc_sel_i,
    input  wire logic [`XLEN-1:0]               pc_jump_i,
    // host loading port
    input  wire logic                           host_we_i,
    input  wire logic [`MEM_ADDR_W-1:0]         host_addr_i,
    input  wire logic [31:0]                    host_wdata_i,
    input  wire logic                           host_perm_we_i,
    input  wire logic [`MEM_ADDR_W-`PAGE_W-1:0] host_perm_page_i,
    input  wire logic                           host_perm_exec_i,
    // toward decode
    output logic                                fetch_valid_o,
    output logic [`XLEN-1:0]                    fetch_pc_o,
    output logic [31:0]                         fetch_instr_o,
    output logic                                bpred_taken_o,
    output logic [`XLEN-1:0]                    bpred_addr_o,
    output logic                                exc_valid_o,
    output exc_cause_t                          exc_cause_o,
    output logic [`XLEN-1:0]                    exc_origin_o
);

    fetch_out_t fetch;

    mem_bus_if fetch_bus (.clk_i(clk_i), .rstn_i(rstn_i));
    mem_bus_if tcm_bus (.clk_i(clk_i), .rstn_i(rstn_i));

    if_stage u_if_stage (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .stall_i       (stall_i),
        .next_pc_sel_i (next_pc_sel_i),
        .pc_jump_i     (pc_jump_i),
        .fetch_bus     (fetch_bus.requester),
        .fetch_o       (fetch)
    );

    // host beats fetch on the shared port
    mem_arbiter u_arbiter (
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .fetch_bus    (fetch_bus.memory),
        .tcm_bus      (tcm_bus.requester)
    );

    inst_tcm u_tcm (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .tcm_bus          (tcm_bus.memory),
        .host_perm_we_i   (host_perm_we_i),
        .host_perm_page_i (host_perm_page_i),
        .host_perm_exec_i (host_perm_exec_i)
    );

    // flatten the fetch packet onto plain ports
    assign fetch_valid_o = fetch.valid;
    assign fetch_pc_o    = fetch.pc;
    assign fetch_instr_o = fetch.instr;
    assign bpred_taken_o = fetch.bpred.taken;
    assign bpred_addr_o  = fetch.bpred.pred_addr;
    assign exc_valid_o   = fetch.ex.valid;
    assign exc_cause_o   = fetch.ex.cause;
    assign exc_origin_o  = fetch.ex.origin;

endmodule

`default_nettype wire

/* verification/fetch_tb.sv */
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb
    import riscv_pkg::*;
    import fetch_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    logic                           clk_i;
    logic                           rstn_i;
    logic                           stall_i;
    next_pc_sel_t                   next_pc_sel_i;
    addr_pc_t                       pc_jump_i;
    logic                           host_we_i;
    logic [`MEM_ADDR_W-1:0]         host_addr_i;
    logic [31:0]                    host_wdata_i;
    logic                           host_perm_we_i;
    logic [`MEM_ADDR_W-`PAGE_W-1:0] host_perm_page_i;
    logic                           host_perm_exec_i;
    logic                           fetch_valid_o;
    addr_pc_t                       fetch_pc_o;
    logic [31:0]                    fetch_instr_o;
    logic                           bpred_taken_o;
    addr_pc_t                       bpred_addr_o;
    logic                           exc_valid_o;
    exc_cause_t                     exc_cause_o;
    addr_pc_t                       exc_origin_o;

    // reference copy of every host write
    logic [31:0] mirror [2 ** (`MEM_ADDR_W - 2)];
    int          seed;
    int          errors;
    int          checks;

    fetch_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic check_pc(input string name, input addr_pc_t exp, input addr_pc_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_instr(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cause(input string name, input exc_cause_t exp,
                               input exc_cause_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // valid, cause and origin in one go
    task automatic check_exc(input string name, input exc_cause_t cause, input addr_pc_t pc);
        check_bit({name, " valid"}, 1'b1, exc_valid_o);
        check_cause({name, " cause"}, cause, exc_cause_o);
        check_pc({name, " origin"}, pc, exc_origin_o);
    endtask

    // poll at the falling edge until a word comes back
    task automatic wait_valid(input string name, input int max_cycles);
        int n;
        n = 0;
        while (fetch_valid_o !== 1'b1 && n < max_cycles) begin
            @(negedge clk_i);
            n++;
        end
        if (fetch_valid_o !== 1'b1) begin
            $display("%s: no valid fetch within %0d cycles", name, max_cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    endtask

    // select applies at the next edge and then returns to hold
    task automatic step(input next_pc_sel_t sel, input addr_pc_t target);
        @(posedge clk_i);
        next_pc_sel_i <= sel;
        pc_jump_i     <= target;
        @(posedge clk_i);
        next_pc_sel_i <= NEXT_PC_SEL_PC;
        @(negedge clk_i);
    endtask

    task automatic host_write(input logic [`MEM_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk_i);
        host_we_i    <= 1'b1;
        host_addr_i  <= addr;
        host_wdata_i <= data;
        mirror[addr[`MEM_ADDR_W-1:2]] = data;
        @(posedge clk_i);
        host_we_i <= 1'b0;
    endtask

    task automatic set_exec(input logic [`MEM_ADDR_W-`PAGE_W-1:0] page, input logic exec);
        @(posedge clk_i);
        host_perm_we_i   <= 1'b1;
        host_perm_page_i <= page;
        host_perm_exec_i <= exec;
        @(posedge clk_i);
        host_perm_we_i <= 1'b0;
    endtask

    // beq x1, x2 with a byte offset
    function automatic logic [31:0] enc_branch(input int off);
        logic [31:0] o;
        o = off;
        return {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], 7'b1100011};
    endfunction

    // jal x1 with a byte offset
    function automatic logic [31:0] enc_jal(input int off);
        logic [31:0] o;
        o = off;
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
    endfunction

    task automatic test_load_sequential();
        addr_pc_t exp_pc;
        logic [31:0] word;
        for (int i = 0; i < 8; i++) begin
            word = $random(seed);
            host_write(12'h200 + 12'(i * 4), word);
        end
        @(negedge clk_i);
        exp_pc = `RESET_PC;
        for (int i = 0; i < 8; i++) begin
            check_pc("load_seq pc", exp_pc, fetch_pc_o);
            check_bit("load_seq valid", 1'b1, fetch_valid_o);
            check_instr("load_seq instr", mirror[exp_pc[11:2]], fetch_instr_o);
            step(NEXT_PC_SEL_PC_4, '0);
            exp_pc = exp_pc + 64'd4;
        end
        check_pc("load_seq last pc", exp_pc, fetch_pc_o);
    endtask

    task automatic test_control();
        step(NEXT_PC_SEL_JUMP, 64'h240);
        check_pc("control jump", 64'h240, fetch_pc_o);
        step(NEXT_PC_SEL_PC, 64'h800);
        check_pc("control hold", 64'h240, fetch_pc_o);
        step(NEXT_PC_SEL_PC_4, 64'h800);
        check_pc("control pc4", 64'h244, fetch_pc_o);
        // spare encoding ignores the target
        step(next_pc_sel_t'(2'b11), 64'h800);
        check_pc("control undefined", 64'h248, fetch_pc_o);
        step(NEXT_PC_SEL_JUMP, 64'h200);
        check_pc("control back", 64'h200, fetch_pc_o);
        check_instr("control instr", mirror[128], fetch_instr_o);
    endtask

    task automatic test_prediction();
        host_write(12'h400, enc_branch(-16));
        host_write(12'h404, enc_branch(32));
        host_write(12'h408, enc_jal(256));
        // add x3, x1, x2
        host_write(12'h40c, 32'h002081b3);
        step(NEXT_PC_SEL_JUMP, 64'h400);
        check_bit("pred backward taken", 1'b1, bpred_taken_o);
        check_pc("pred backward target", 64'h3f0, bpred_addr_o);
        step(NEXT_PC_SEL_PC_4, '0);
        check_bit("pred forward taken", 1'b0, bpred_taken_o);
        check_pc("pred forward target", 64'h0, bpred_addr_o);
        step(NEXT_PC_SEL_PC_4, '0);
        check_bit("pred jal taken", 1'b1, bpred_taken_o);
        check_pc("pred jal target", 64'h508, bpred_addr_o);
        step(NEXT_PC_SEL_PC_4, '0);
        check_bit("pred alu taken", 1'b0, bpred_taken_o);
        check_pc("pred alu target", 64'h0, bpred_addr_o);
    endtask

    task automatic test_exceptions();
        step(NEXT_PC_SEL_JUMP, 64'h202);
        check_exc("exc misaligned", INSTR_ADDR_MISALIGNED, 64'h202);
        check_bit("exc misaligned fetch", 1'b0, fetch_valid_o);
        step(NEXT_PC_SEL_JUMP, 64'h1000);
        check_exc("exc above 4k", INSTR_ACCESS_FAULT, 64'h1000);
        // page 3 covers 0x300 to 0x3ff
        set_exec(4'd3, 1'b0);
        step(NEXT_PC_SEL_JUMP, 64'h300);
        check_exc("exc page", INSTR_PAGE_FAULT, 64'h300);
        step(NEXT_PC_SEL_JUMP, 64'h302);
        check_exc("exc misaligned over page", INSTR_ADDR_MISALIGNED, 64'h302);
        step(NEXT_PC_SEL_JUMP, 64'h1300);
        check_exc("exc access over page", INSTR_ACCESS_FAULT, 64'h1300);
        set_exec(4'd3, 1'b1);
        step(NEXT_PC_SEL_JUMP, 64'h300);
        check_bit("exc page restored", 1'b0, exc_valid_o);
    endtask

    task automatic test_conflict_stall();
        addr_pc_t exp_pc;
        logic [31:0] word;
        step(NEXT_PC_SEL_JUMP, 64'h1000);
        exp_pc = 64'h1000;
        word   = $random(seed);
        // host write while the fetch would hit an access fault
        @(posedge clk_i);
        host_we_i     <= 1'b1;
        host_addr_i   <= 12'hf00;
        host_wdata_i  <= word;
        next_pc_sel_i <= NEXT_PC_SEL_JUMP;
        pc_jump_i     <= 64'h200;
        mirror[10'h3c0] = word;
        @(negedge clk_i);
        check_bit("conflict valid", 1'b0, fetch_valid_o);
        check_bit("conflict exc", 1'b0, exc_valid_o);
        check_pc("conflict pc", exp_pc, fetch_pc_o);
        @(posedge clk_i);
        host_we_i     <= 1'b0;
        next_pc_sel_i <= NEXT_PC_SEL_PC;
        exp_pc = 64'h200;
        @(negedge clk_i);
        check_pc("conflict next pc", exp_pc, fetch_pc_o);
        check_instr("conflict next instr", mirror[exp_pc[11:2]], fetch_instr_o);
        // stall drops the request but pc still moves
        @(posedge clk_i);
        stall_i       <= 1'b1;
        next_pc_sel_i <= NEXT_PC_SEL_PC_4;
        @(negedge clk_i);
        check_bit("stall valid", 1'b0, fetch_valid_o);
        check_pc("stall pc", exp_pc, fetch_pc_o);
        @(posedge clk_i);
        stall_i       <= 1'b0;
        next_pc_sel_i <= NEXT_PC_SEL_PC;
        exp_pc = exp_pc + 64'd4;
        @(negedge clk_i);
        wait_valid("stall release", 4);
        check_pc("stall next pc", exp_pc, fetch_pc_o);
        check_instr("stall next instr", mirror[exp_pc[11:2]], fetch_instr_o);
        // word written during the conflict
        step(NEXT_PC_SEL_JUMP, 64'hf00);
        check_instr("conflict readback", word, fetch_instr_o);
    endtask

    initial begin
        seed             = 32'h96a4;
        errors           = 0;
        checks           = 0;
        rstn_i           = 1'b0;
        stall_i          = 1'b0;
        next_pc_sel_i    = NEXT_PC_SEL_PC;
        pc_jump_i        = '0;
        host_we_i        = 1'b0;
        host_addr_i      = '0;
        host_wdata_i     = '0;
        host_perm_we_i   = 1'b0;
        host_perm_page_i = '0;
        host_perm_exec_i = 1'b0;
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        wait_valid("reset", 10);
        check_pc("reset pc", `RESET_PC, fetch_pc_o);
        check_bit("reset exc", 1'b0, exc_valid_o);
        test_load_sequential();
        test_control();
        test_prediction();
        test_exceptions();
        test_conflict_stall();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+logic
logic/riscv_pkg.sv
logic/fetch_pkg.sv
logic/mem_bus_if.sv
logic/branch_predecoder.sv
logic/if_stage.sv
logic/mem_arbiter.sv
logic/inst_tcm.sv
logic/fetch_top.sv
verification/fetch_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := fetch_tb
RTL_TOP  := fetch_top
FLIST    := flist.f
PASS_MSG := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
